// File: project.f
source/heapPkg.sv
source/heapSequencer.sv
source/scanCounter.sv
source/arrayTable.sv
source/arrayStore.sv
source/heapMemory.sv
tb/heapChecker.sv
tb/heapMemoryTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module heapMemoryTb -o heapMemorySim
output="$(./obj_dir/heapMemorySim)"
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi

// File: source/arrayStore.sv
// Element memory, one cycle synchronous read, write on the edge; not cleared by reset
// Arithmetic wraps modulo 2^dataBits and works on the last read element

interface storeBus import heapPkg::*; ();
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   element;
  logic [dataBits-1:0]    operand;                  // Request input word
  heapAction              action;
  logic                   readEnable;
  logic                   writeEnable;
  logic [dataBits-1:0]    readData;
  logic [dataBits-1:0]    result;                   // Unit output on readData
  logic                   match;

  modport sequencer (output array, element, operand, action, readEnable, writeEnable,
                     input  readData, result, match);
  modport store     (input  array, element, operand, action, readEnable, writeEnable,
                     output readData, result, match);
endinterface

module arrayStore import heapPkg::*; (
  input logic    clock,
  storeBus.store bus
);

  localparam int addressWidth = addressBits + indexBits;

  logic [dataBits-1:0]     elements [arrayCount * arrayLength];  // Arrays in fixed blocks
  logic [addressWidth-1:0] address;
  logic [dataBits-1:0]     writeData;

  assign address = {bus.array, bus.element};        // Array selects the block

  // --------------------------------------------------
  // Arithmetic and logic unit
  always_comb begin
    case (bus.action)
      actionAdd:      bus.result = bus.readData + bus.operand;
      actionSubtract: bus.result = bus.readData - bus.operand;
      actionOr:       bus.result = bus.readData | bus.operand;
      actionXor:      bus.result = bus.readData ^ bus.operand;
      actionAnd:      bus.result = bus.readData & bus.operand;
      default:        bus.result = bus.readData;    // Pass through
    endcase
  end

  // Write and push store the operand, the rest store the new value
  assign writeData = isArithmetic(bus.action) ? bus.result : bus.operand;

  // Search compare on the element read last cycle
  assign bus.match = bus.readData == bus.operand;

  // --------------------------------------------------
  // Memory
  always_ff @(posedge clock) begin
    if (bus.readEnable)
      bus.readData <= elements[address];
    if (bus.writeEnable)
      elements[address] <= writeData;
  end

endmodule

// File: source/arrayTable.sv
// Sizes, allocation flags and freed stack of the heap; element data lives elsewhere
// Checks are combinational on the captured request; changes land on the strobe edge
// A freed array is reused before a never-used one; no compaction of numbers

interface tableBus import heapPkg::*; ();
  heapAction              action;                   // Captured request
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic                   commit;                   // Apply clear, alloc or free
  logic                   newSize;                  // Apply write, push or pop size
  logic                   allocOk;
  logic                   readOk;
  heapError               error;
  sizeWord                size;
  logic [addressBits-1:0] allocNumber;              // Array an alloc would get

  modport sequencer (output action, array, index, commit, newSize,
                     input  allocOk, readOk, error, size, allocNumber);
  modport tableSide (input  action, array, index, commit, newSize,
                     output allocOk, readOk, error, size, allocNumber);
endinterface

module arrayTable import heapPkg::*; (
  input logic        clock,
  input logic        reset,
  tableBus.tableSide bus
);

  sizeWord                sizes [arrayCount];
  logic [arrayCount-1:0]  allocated;                // One flag per array
  logic [addressBits-1:0] freedStack [arrayCount];
  logic [addressBits:0]   freedTop;                 // Entries on the freed stack
  logic [addressBits:0]   allocCount;               // Arrays ever handed out
  logic [addressBits-1:0] stackTop;
  sizeWord                currentSize;
  logic                   known;
  logic                   flagSet;
  logic                   inBounds;
  logic                   outOfMemory;

  // --------------------------------------------------
  // Checks
  assign currentSize     = sizes[bus.array];
  assign known           = {1'b0, bus.array} < allocCount;
  assign flagSet         = allocated[bus.array];
  assign inBounds        = sizeWord'(bus.index) < currentSize;
  assign stackTop        = addressBits'(freedTop - 1'b1);
  assign outOfMemory     = freedTop == '0 && allocCount == (addressBits + 1)'(arrayCount);
  assign bus.size        = currentSize;
  assign bus.allocOk     = known && flagSet;
  assign bus.readOk      = known && flagSet && inBounds;
  assign bus.allocNumber = (freedTop != '0) ? freedStack[stackTop]
                                            : allocCount[addressBits-1:0];

  always_comb begin
    if (bus.action == actionAlloc)
      bus.error = outOfMemory ? errorOutOfMemory : errorNone;
    else if (!known)
      bus.error = errorNotAllocated;
    else if (!flagSet)
      bus.error = errorFreed;                       // Also a second free
    else if (!inBounds)
      bus.error = errorOutOfBounds;
    else
      bus.error = errorNone;
  end

  // --------------------------------------------------
  // Updates
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocCount <= '0;
      freedTop   <= '0;
      allocated  <= '0;
      for (int i = 0; i < arrayCount; i++) sizes[i] <= '0;
    end else if (bus.commit) begin
      case (bus.action)
        actionClear: begin
          allocCount <= '0;
          freedTop   <= '0;
          allocated  <= '0;
          for (int i = 0; i < arrayCount; i++) sizes[i] <= '0;
        end
        actionAlloc: begin
          if (freedTop != '0)
            freedTop <= freedTop - 1'b1;            // Reuse most recently freed
          else
            allocCount <= allocCount + 1'b1;
          allocated[bus.allocNumber] <= 1'b1;
          sizes[bus.allocNumber]     <= '0;         // New array starts empty
        end
        actionFree: begin
          freedTop             <= freedTop + 1'b1;
          allocated[bus.array] <= 1'b0;             // Own flag, not the stack slot
        end
        default: ;
      endcase
    end else if (bus.newSize) begin
      case (bus.action)
        actionWrite:
          if (!inBounds) sizes[bus.array] <= sizeWord'(bus.index) + 1'b1;  // Grow to index
        actionPush: sizes[bus.array] <= currentSize + 1'b1;
        actionPop:  sizes[bus.array] <= currentSize - 1'b1;
        default: ;
      endcase
    end
  end

  // Freed stack entries
  always_ff @(posedge clock) begin
    if (bus.commit && bus.action == actionFree)
      freedStack[freedTop[addressBits-1:0]] <= bus.array;
  end

endmodule

// File: source/heapMemory.sv
// Heap top level; start is taken only while busy is low, done pulses once per request
// Out and error hold between done pulses, out is overwritten by the next answer
module heapMemory import heapPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  heapAction              action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output heapError               error,
  output logic                   busy,
  output logic                   done
);

  tableBus tableLink ();                            // Sequencer to sizes and flags
  storeBus storeLink ();                            // Sequencer to element memory

  logic                 scanLoad;
  logic [indexBits-1:0] scanPosition;
  logic                 scanLast;

  heapSequencer u_sequencer (
    .clock,
    .reset,
    .start,
    .action,
    .array,
    .index,
    .in,
    .tableIf      (tableLink.sequencer),
    .storeIf      (storeLink.sequencer),
    .scanLoad     (scanLoad),
    .scanPosition (scanPosition),
    .scanLast     (scanLast),
    .out,
    .error,
    .busy,
    .done
  );

  scanCounter u_scanCounter (
    .clock,
    .reset,
    .load     (scanLoad),
    .limit    (tableLink.size),                     // Search covers current size
    .position (scanPosition),
    .last     (scanLast),
    .running  ()
  );

  arrayTable u_arrayTable (
    .clock,
    .reset,
    .bus (tableLink.tableSide)
  );

  arrayStore u_arrayStore (
    .clock,
    .bus (storeLink.store)
  );

endmodule

// File: source/heapPkg.sv
// Heap of arrayCount arrays with arrayLength elements of dataBits each
// Action codes outside the enum do nothing
// errorNone means the request took effect
package heapPkg;

  // --------------------------------------------------
  // Sizes
  localparam int addressBits = 2;                   // Bits in an array number
  localparam int indexBits   = 3;                   // Bits in an index
  localparam int dataBits    = 12;                  // Bits in an element
  localparam int arrayCount  = 4;                   // Arrays in the heap
  localparam int arrayLength = 8;                   // Elements per array
  localparam int actionBits  = 8;                   // Width of an action code
  localparam int errorBits   = 3;                   // Width of an error code

  typedef logic [indexBits:0] sizeWord;             // Size 0 to arrayLength inclusive

  // --------------------------------------------------
  // Request and answer codes
  typedef enum logic [actionBits-1:0] {
    actionClear    = 8'd1,                          // Drop all arrays
    actionWrite    = 8'd2,
    actionRead     = 8'd3,
    actionSize     = 8'd4,
    actionIndex    = 8'd7,                          // Last match, multi-cycle
    actionPush     = 8'd14,
    actionPop      = 8'd15,
    actionAlloc    = 8'd18,
    actionFree     = 8'd19,
    actionAdd      = 8'd20,                         // Returns new value
    actionSubtract = 8'd22,
    actionOr       = 8'd28,
    actionXor      = 8'd29,
    actionAnd      = 8'd30
  } heapAction;

  typedef enum logic [errorBits-1:0] {
    errorNone         = 3'd0,
    errorNotAllocated = 3'd1,                       // Array number at or above count
    errorFreed        = 3'd2,                       // Allocation flag clear
    errorOutOfBounds  = 3'd3,                       // Index at or above size
    errorFull         = 3'd4,
    errorEmpty        = 3'd5,
    errorOutOfMemory  = 3'd6
  } heapError;

  // Read-modify-write actions
  function automatic logic isArithmetic(heapAction code);
    return code inside {actionAdd, actionSubtract, actionOr, actionXor, actionAnd};
  endfunction

endpackage

// File: source/heapSequencer.sv
// Accepts one request per start while busy is low; no queueing of requests
// Plain actions finish two edges after acceptance, index after size plus two
// Out keeps its old value when a check fails or the action returns nothing
module heapSequencer import heapPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  heapAction              action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  tableBus.sequencer             tableIf,
  storeBus.sequencer             storeIf,
  output logic                   scanLoad,
  input  logic [indexBits-1:0]   scanPosition,
  input  logic                   scanLast,
  output logic [dataBits-1:0]    out,
  output heapError               error,
  output logic                   busy,
  output logic                   done
);

  enum logic [1:0] {stateIdle, stateFetch, stateScan, stateFinish} state;

  heapAction              reqAction;                // Captured request
  logic [addressBits-1:0] reqArray;
  logic [indexBits-1:0]   reqIndex;
  logic [dataBits-1:0]    reqIn;
  sizeWord                found;                    // Last hit so far, plus one
  sizeWord                indexResult;
  heapError               checkError;
  logic                   ok;
  logic                   storesElement;
  logic                   changesTable;
  logic                   changesSize;

  // --------------------------------------------------
  // Pick the check that applies to the action
  always_comb begin
    checkError = errorNone;
    case (reqAction)
      actionWrite, actionSize, actionIndex, actionFree:
        if (!tableIf.allocOk) checkError = tableIf.error;
      actionRead, actionAdd, actionSubtract, actionOr, actionXor, actionAnd:
        if (!tableIf.readOk) checkError = tableIf.error;
      actionPush: begin
        if (!tableIf.allocOk) checkError = tableIf.error;
        else if (tableIf.size == sizeWord'(arrayLength)) checkError = errorFull;
      end
      actionPop: begin
        if (!tableIf.allocOk) checkError = tableIf.error;
        else if (tableIf.size == '0) checkError = errorEmpty;
      end
      actionAlloc: checkError = tableIf.error;      // Out of memory or none
      default: checkError = errorNone;              // Clear and unknown codes
    endcase
  end

  assign ok            = checkError == errorNone;
  assign storesElement = reqAction inside {actionWrite, actionPush} || isArithmetic(reqAction);
  assign changesTable  = reqAction inside {actionClear, actionAlloc, actionFree};
  assign changesSize   = reqAction inside {actionWrite, actionPush, actionPop};
  assign indexResult   = (tableIf.size != '0 && storeIf.match) ? tableIf.size : found;

  // --------------------------------------------------
  // Bus drive
  assign tableIf.action      = reqAction;
  assign tableIf.array       = reqArray;
  assign tableIf.index       = reqIndex;
  assign tableIf.commit      = state == stateFinish && ok && changesTable;
  assign tableIf.newSize     = state == stateFinish && ok && changesSize;
  assign storeIf.array       = reqArray;
  assign storeIf.operand     = reqIn;
  assign storeIf.action      = reqAction;
  assign storeIf.readEnable  = state == stateFetch || state == stateScan;
  assign storeIf.writeEnable = state == stateFinish && ok && storesElement;
  assign scanLoad            = state == stateFetch && reqAction == actionIndex && ok;
  assign busy                = state != stateIdle;

  always_comb begin
    case (state)
      stateFetch: storeIf.element = (reqAction == actionPop) ?
                                    indexBits'(tableIf.size - 1'b1) : reqIndex;  // Top of stack
      stateScan:  storeIf.element = scanPosition;
      default:    storeIf.element = (reqAction == actionPush) ?
                                    indexBits'(tableIf.size) : reqIndex;         // Next free slot
    endcase
  end

  // --------------------------------------------------
  // Control FSM
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state     <= stateIdle;
      reqAction <= actionClear;
      out       <= '0;
      error     <= errorNone;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;                                 // Single cycle pulse
      case (state)
        stateIdle: if (start) begin
          state     <= stateFetch;
          reqAction <= action;
        end
        stateFetch: state <= (scanLoad && !scanLast) ? stateScan : stateFinish;
        stateScan:  if (scanLast) state <= stateFinish;
        default: begin                              // Finish, answer this edge
          state <= stateIdle;
          done  <= 1'b1;
          error <= checkError;
          if (ok) begin
            case (reqAction)
              actionWrite: out <= reqIn;
              actionRead, actionPop: out <= storeIf.readData;
              actionAdd, actionSubtract, actionOr, actionXor, actionAnd: out <= storeIf.result;
              actionSize:  out <= dataBits'(tableIf.size);
              actionAlloc: out <= dataBits'(tableIf.allocNumber);
              actionIndex: out <= dataBits'(indexResult);
              default:     out <= out;
            endcase
          end
        end
      endcase
    end
  end

  // Request capture and search hits; read data lags position by one
  always_ff @(posedge clock) begin
    if (state == stateIdle && start) begin
      reqArray <= array;
      reqIndex <= index;
      reqIn    <= in;
    end
    if (state == stateFetch)
      found <= '0;
    else if (state == stateScan && scanPosition != '0 && storeIf.match)
      found <= sizeWord'(scanPosition);             // Hit at position minus one
  end

endmodule

// File: source/scanCounter.sv
// Walks positions 0 to limit-1, one per cycle after load
// A zero limit raises last during the load cycle and never runs
module scanCounter import heapPkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 load,
  input  sizeWord              limit,
  output logic [indexBits-1:0] position,
  output logic                 last,
  output logic                 running
);

  sizeWord limitReg;                                // Limit held for the scan

  // Last is early on an empty scan
  assign last = load ? (limit == '0)
                     : (running && sizeWord'(position) == limitReg - 1'b1);

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      position <= '0;
      running  <= 1'b0;
      limitReg <= '0;
    end else if (load) begin
      position <= '0;
      running  <= limit != '0;
      limitReg <= limit;
    end else if (running) begin
      if (last)
        running <= 1'b0;                            // Hold final position
      else
        position <= position + 1'b1;
    end
  end

endmodule

// File: tb/heapChecker.sv
// Compares out and error at every done pulse with the values latched when start was taken
// Expected values must be stable at the rising edge that accepts the request
module heapChecker import heapPkg::*; (
  input  logic                clock,
  input  logic                reset,
  input  logic                start,
  input  logic                busy,
  input  logic                done,
  input  logic [dataBits-1:0] out,
  input  heapError            error,
  input  logic [dataBits-1:0] expectedOut,
  input  heapError            expectedError,
  output int                  checkCount,
  output int                  failCount
);

  logic [dataBits-1:0] wantOut;                     // Latched at acceptance
  heapError            wantError;
  logic                pending;                     // Request in flight

  always @(posedge clock or negedge reset) begin
    if (!reset) begin
      checkCount = 0;
      failCount  = 0;
      pending    = 1'b0;
      wantOut    = '0;
      wantError  = errorNone;
    end else begin
      // Answer of the finishing request first
      if (done) begin
        checkCount = checkCount + 1;
        if (!pending) begin
          $display("Done pulse arrived with no request outstanding");
          failCount = failCount + 1;
        end else begin
          if (out !== wantOut) begin
            $display("Fail out: got %h expected %h", out, wantOut);
            failCount = failCount + 1;
          end
          if (error !== wantError) begin
            $display("Fail error: got %h expected %h", error, wantError);
            failCount = failCount + 1;
          end
          if (busy !== 1'b0) begin                  // Busy falls with done
            $display("Fail busy: got %h expected %h", busy, 1'b0);
            failCount = failCount + 1;
          end
        end
        pending = 1'b0;
      end else if (pending && busy !== 1'b1) begin  // Busy holds until done
        $display("Fail busy: got %h expected %h", busy, 1'b1);
        failCount = failCount + 1;
      end
      // Then a request taken on this same edge
      if (start && !busy) begin
        wantOut   = expectedOut;
        wantError = expectedError;
        pending   = 1'b1;
      end
    end
  end

endmodule

// File: tb/heapMemoryTb.sv
// Requests run back to back, the next start is given in the cycle that done is high
// Expected answers come from a model of sizes, flags, freed stack and contents
// Only elements that were written are ever read or searched
module heapMemoryTb import heapPkg::*; ();

  logic                   clock;
  logic                   reset;
  logic                   start;
  heapAction              action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    in;
  logic [dataBits-1:0]    out;
  heapError               error;
  logic                   busy;
  logic                   done;
  logic [dataBits-1:0]    expectedOut;              // To the checker
  heapError               expectedError;
  int                     checkCount;
  int                     failCount;
  int                     testChecks;               // Counts at test start
  int                     testFails;
  logic                   hung;                     // Set by a missing done

  // --------------------------------------------------
  // Reference model state
  int                  modelSize [arrayCount];
  logic                modelFlag [arrayCount];
  int                  modelFreed [arrayCount];     // Freed stack
  int                  modelFreedTop;
  int                  modelCount;                  // Arrays ever handed out
  logic [dataBits-1:0] modelMem [arrayCount][arrayLength];
  logic [dataBits-1:0] modelOut;                    // Out holds between answers

  heapMemory u_dut (
    .clock, .reset, .start, .action, .array, .index, .in,
    .out, .error, .busy, .done
  );

  heapChecker u_checker (
    .clock, .reset, .start, .busy, .done, .out, .error,
    .expectedOut, .expectedError, .checkCount, .failCount
  );

  always #4 clock = !clock;                         // Period 8

  // Applies one request to the model, returns out and error
  function automatic logic [dataBits-1:0] expectOp(input heapAction act, input int arr,
      input int idx, input logic [dataBits-1:0] word, output heapError err);
    logic [dataBits-1:0] value;
    int                  slot;
    err   = errorNone;
    value = modelOut;
    slot  = -1;
    if (act == actionClear) begin
      for (int i = 0; i < arrayCount; i++) begin
        modelSize[i] = 0;
        modelFlag[i] = 1'b0;
      end
      modelCount    = 0;
      modelFreedTop = 0;
    end else if (act == actionAlloc) begin
      if (modelFreedTop > 0) begin                  // Freed arrays first
        modelFreedTop = modelFreedTop - 1;
        slot = modelFreed[modelFreedTop];
      end else if (modelCount < arrayCount) begin
        slot       = modelCount;
        modelCount = modelCount + 1;
      end
      if (slot < 0) err = errorOutOfMemory;
      else begin
        modelFlag[slot] = 1'b1;
        modelSize[slot] = 0;
        value = dataBits'(slot);
      end
    end else if (arr >= modelCount) err = errorNotAllocated;
    else if (!modelFlag[arr]) err = errorFreed;
    else begin
      case (act)
        actionWrite: begin
          modelMem[arr][idx] = word;
          if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;
          value = word;
        end
        actionSize: value = dataBits'(modelSize[arr]);
        actionFree: begin
          modelFlag[arr] = 1'b0;
          modelFreed[modelFreedTop] = arr;
          modelFreedTop = modelFreedTop + 1;
        end
        actionPush:
          if (modelSize[arr] == arrayLength) err = errorFull;
          else begin
            modelMem[arr][modelSize[arr]] = word;
            modelSize[arr] = modelSize[arr] + 1;
          end
        actionPop:
          if (modelSize[arr] == 0) err = errorEmpty;
          else begin
            modelSize[arr] = modelSize[arr] - 1;
            value = modelMem[arr][modelSize[arr]];
          end
        actionIndex: begin                          // Last hit plus one
          value = '0;
          for (int i = 0; i < modelSize[arr]; i++)
            if (modelMem[arr][i] == word) value = dataBits'(i + 1);
        end
        default:                                    // Read and arithmetic
          if (idx >= modelSize[arr]) err = errorOutOfBounds;
          else begin
            case (act)
              actionAdd:      value = modelMem[arr][idx] + word;  // Wraps at 4096
              actionSubtract: value = modelMem[arr][idx] - word;
              actionOr:       value = modelMem[arr][idx] | word;
              actionXor:      value = modelMem[arr][idx] ^ word;
              actionAnd:      value = modelMem[arr][idx] & word;
              default:        value = modelMem[arr][idx];
            endcase
            modelMem[arr][idx] = value;
          end
      endcase
    end
    modelOut = value;
    return value;
  endfunction

  function automatic logic [dataBits-1:0] randomWord();
    return dataBits'($urandom);
  endfunction

  // --------------------------------------------------
  // Drive one request on the falling edge, wait for done
  task automatic issueOp(input heapAction act, input int arr, input int idx,
      input logic [dataBits-1:0] word);
    int cycles;
    if (!hung) begin
      expectedOut = expectOp(act, arr, idx, word, expectedError);
      action = act;
      array  = addressBits'(arr);
      index  = indexBits'(idx);
      in     = word;
      start  = 1'b1;
      @(negedge clock);
      start  = 1'b0;
      cycles = 1;
      while (!done && cycles < 40) begin
        @(negedge clock);
        cycles = cycles + 1;
      end
      if (!done) begin
        $display("No done pulse within 40 cycles for action %s", act.name());
        hung = 1'b1;
      end
    end
  endtask

  task automatic endTest(input string name);
    @(negedge clock);                               // Last compare lands in between
    $display("%s: %0d checks, %0d failures", name, checkCount - testChecks,
             failCount - testFails);
    testChecks = checkCount;
    testFails  = failCount;
  endtask

  // --------------------------------------------------
  // Tests
  task automatic testAllocFree();
    for (int i = 0; i < 5; i++) issueOp(actionAlloc, 0, 0, '0);  // Fifth runs out
    issueOp(actionFree, 2, 0, '0);
    issueOp(actionFree, 1, 0, '0);
    issueOp(actionAlloc, 0, 0, '0);                 // Gets 1 back
    issueOp(actionAlloc, 0, 0, '0);                 // Then 2
    issueOp(actionFree, 3, 0, '0);
    issueOp(actionFree, 3, 0, '0);                  // Already freed
    endTest("Alloc and free");
  endtask

  task automatic testWriteRead();
    issueOp(actionClear, 0, 0, '0);
    issueOp(actionAlloc, 0, 0, '0);
    issueOp(actionAlloc, 0, 0, '0);
    issueOp(actionWrite, 0, 3, randomWord());       // Size jumps to 4
    issueOp(actionWrite, 0, 1, randomWord());
    issueOp(actionWrite, 0, 0, randomWord());
    issueOp(actionWrite, 0, 2, randomWord());
    issueOp(actionSize, 0, 0, '0);
    issueOp(actionSize, 1, 0, '0);
    for (int i = 0; i < 4; i++) issueOp(actionRead, 0, i, '0);
    issueOp(actionRead, 0, 5, '0);                  // Past the size
    issueOp(actionRead, 1, 0, '0);
    issueOp(actionRead, 3, 0, '0);                  // Never allocated
    issueOp(actionWrite, 2, 0, randomWord());
    endTest("Write, read and size");
  endtask

  task automatic testPushPop();
    for (int i = 0; i < 9; i++) issueOp(actionPush, 1, 0, randomWord());
    issueOp(actionSize, 1, 0, '0);
    for (int i = 0; i < 9; i++) issueOp(actionPop, 1, 0, '0);
    endTest("Push and pop");
  endtask

  task automatic testArithmetic();
    heapAction ops [5] = '{actionAdd, actionSubtract, actionOr, actionXor, actionAnd};
    int        pick;
    int        idx;
    for (int n = 0; n < 20; n++) begin
      pick = $urandom % 5;
      idx  = $urandom % 4;                          // Array 0 holds four elements
      issueOp(ops[pick], 0, idx, randomWord());
      issueOp(actionRead, 0, idx, '0);              // Stored value
    end
    endTest("Arithmetic");
  endtask

  task automatic testIndex();
    int fill;
    issueOp(actionIndex, 1, 0, randomWord());       // Empty array
    for (int round = 0; round < 8; round++) begin
      issueOp(actionFree, 1, 0, '0);
      issueOp(actionAlloc, 0, 0, '0);               // Array 1 again, size zero
      fill = $urandom % 9;
      for (int i = 0; i < fill; i++) issueOp(actionWrite, 1, i, dataBits'($urandom % 4));
      for (int k = 0; k < 3; k++) issueOp(actionIndex, 1, 0, dataBits'($urandom % 5));
    end
    endTest("Index search");
  endtask

  task automatic testClear();
    issueOp(actionClear, 0, 0, '0);
    for (int a = 0; a < arrayCount; a++) issueOp(actionSize, a, 0, '0);
    issueOp(actionRead, 0, 0, '0);
    issueOp(actionAlloc, 0, 0, '0);                 // Numbering restarts at 0
    issueOp(actionAlloc, 0, 0, '0);
    issueOp(actionPush, 0, 0, randomWord());
    issueOp(actionWrite, 1, 0, randomWord());
    issueOp(actionRead, 1, 0, '0);
    issueOp(actionPop, 0, 0, '0);
    issueOp(actionSize, 1, 0, '0);
    endTest("Clear");
  endtask

  initial begin
    clock         = 1'b0;
    reset         = 1'b0;
    start         = 1'b0;
    action        = actionClear;
    array         = '0;
    index         = '0;
    in            = '0;
    expectedOut   = '0;
    expectedError = errorNone;
    hung          = 1'b0;
    testChecks    = 0;
    testFails     = 0;
    modelOut      = '0;
    modelCount    = 0;
    modelFreedTop = 0;
    for (int i = 0; i < arrayCount; i++) begin
      modelSize[i] = 0;
      modelFlag[i] = 1'b0;
    end
    void'($urandom(18));
    repeat (16) @(negedge clock);                   // Reset for 16 cycles
    reset = 1'b1;
    testAllocFree();
    testWriteRead();
    testPushPop();
    testArithmetic();
    testIndex();
    testClear();
    $display("Total: %0d checks, %0d failures", checkCount, failCount);
    if (hung || failCount != 0)
      $display("TEST FAIL");
    else
      $display("TEST PASS");
    $finish;
  end

endmodule
